// ==== hdl/rv_mem_isa_pkg.sv ====
`default_nettype none

// RV32 load/store encodings shared by the data-memory path
package rv_mem_isa_pkg;

    localparam int WORD_W         = 32;
    localparam int BYTES_PER_WORD = WORD_W / 8;

    typedef logic [WORD_W-1:0] word_t; // Architectural data word

    // funct3 field of LB/LH/LW/LBU/LHU and SB/SH/SW
    typedef enum logic [2:0] {
        f3_byte   = 3'b000, // LB / SB
        f3_half   = 3'b001, // LH / SH
        f3_word   = 3'b010, // LW / SW
        f3_byte_u = 3'b100, // LBU
        f3_half_u = 3'b101  // LHU
    } mem_funct3_e;

endpackage

`default_nettype wire

// ==== hdl/lsu_if_pkg.sv ====
`default_nettype none

// Request and response records between LSU, ROB and the data memory
package lsu_if_pkg;

    localparam int ADDR_W = 11;

    typedef logic [ADDR_W-1:0] mem_addr_t; // Word index, not byte address

    // Speculative load from the LSU
    typedef struct packed {
        logic                        valid;
        mem_addr_t                   addr;
        rv_mem_isa_pkg::mem_funct3_e funct3;
    } spec_load_req_t;

    // Commit of a load or store from the ROB
    typedef struct packed {
        logic                        valid;
        logic                        is_store;
        mem_addr_t                   addr;
        rv_mem_isa_pkg::mem_funct3_e funct3;
        rv_mem_isa_pkg::word_t       value; // Store data or speculated load value
    } commit_req_t;

    typedef struct packed {
        logic done;
        logic exception; // Load value differs from memory at commit
    } commit_resp_t;

endpackage

`default_nettype wire

// ==== hdl/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int MEM_WORDS = 2048
) (
    input  wire                                               clk,
    input  wire                                               reset,

    // Speculative read port, registered
    input  wire                                               spec_rd_en,
    input  wire lsu_if_pkg::mem_addr_t                        spec_rd_addr,
    output rv_mem_isa_pkg::word_t                             spec_rd_word,

    // Commit read port, combinational
    input  wire lsu_if_pkg::mem_addr_t                        cmt_rd_addr,
    output rv_mem_isa_pkg::word_t                             cmt_rd_word,

    // Byte-lane write port
    input  wire                                               wr_en,
    input  wire lsu_if_pkg::mem_addr_t                        wr_addr,
    input  wire [rv_mem_isa_pkg::BYTES_PER_WORD-1:0]          wr_lanes,
    input  wire rv_mem_isa_pkg::word_t                        wr_data
);

    rv_mem_isa_pkg::word_t mem [MEM_WORDS];

    logic spec_in_range;
    logic cmt_in_range;
    logic wr_in_range;

    // Addresses past the array read as zero and drop writes
    assign spec_in_range = int'(spec_rd_addr) < MEM_WORDS;
    assign cmt_in_range  = int'(cmt_rd_addr) < MEM_WORDS;
    assign wr_in_range   = int'(wr_addr) < MEM_WORDS;

    // Array contents; reset restores the index+3 image
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= rv_mem_isa_pkg::word_t'(i + 3);
            end
        end else if (wr_en && wr_in_range) begin
            for (int l = 0; l < rv_mem_isa_pkg::BYTES_PER_WORD; l++) begin
                if (wr_lanes[l]) begin
                    mem[wr_addr][8*l +: 8] <= wr_data[8*l +: 8]; // Only selected lanes
                end
            end
        end
    end

    // Same-edge store is not visible here: nonblocking read sees the old word
    always_ff @(posedge clk) begin
        if (spec_rd_en) begin
            if (spec_in_range) begin
                spec_rd_word <= mem[spec_rd_addr];
            end else begin
                spec_rd_word <= '0;
            end
        end
    end

    // Commit reload follows the address within the cycle
    always_comb begin
        if (cmt_in_range) begin
            cmt_rd_word = mem[cmt_rd_addr];
        end else begin
            cmt_rd_word = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/load_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

// Load data shaping by funct3
module load_extend (
    input  wire rv_mem_isa_pkg::word_t       raw,
    input  wire rv_mem_isa_pkg::mem_funct3_e funct3,
    output rv_mem_isa_pkg::word_t            data
);

    logic [7:0]  raw_byte;
    logic [15:0] raw_half;

    assign raw_byte = raw[7:0];  // Low lane only
    assign raw_half = raw[15:0];

    always_comb begin
        case (funct3)
            rv_mem_isa_pkg::f3_byte: begin
                data = {{24{raw_byte[7]}}, raw_byte}; // Sign from bit 7
            end
            rv_mem_isa_pkg::f3_half: begin
                data = {{16{raw_half[15]}}, raw_half}; // Sign from bit 15
            end
            rv_mem_isa_pkg::f3_word: begin
                data = raw;
            end
            rv_mem_isa_pkg::f3_byte_u: begin
                data = {24'd0, raw_byte};
            end
            rv_mem_isa_pkg::f3_half_u: begin
                data = {16'd0, raw_half};
            end
            default: begin
                data = '0; // Unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/commit_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_unit (
    input  wire                                      clk,
    input  wire                                      reset,

    input  wire lsu_if_pkg::commit_req_t             commit_req,
    input  wire rv_mem_isa_pkg::word_t               checked_load, // Extended reload

    // Commit read port address
    output lsu_if_pkg::mem_addr_t                    rd_addr,

    // Store write port
    output logic                                     wr_en,
    output lsu_if_pkg::mem_addr_t                    wr_addr,
    output logic [rv_mem_isa_pkg::BYTES_PER_WORD-1:0] wr_lanes,
    output rv_mem_isa_pkg::word_t                    wr_data,

    output lsu_if_pkg::commit_resp_t                 commit_resp
);

    logic [rv_mem_isa_pkg::BYTES_PER_WORD-1:0] store_lanes;
    logic                                      store_commit;
    logic                                      load_commit;
    logic                                      load_mismatch;

    assign store_commit = commit_req.valid && commit_req.is_store;
    assign load_commit  = commit_req.valid && !commit_req.is_store;

    // Store size to lane mask, data always sits in the low lanes
    always_comb begin
        case (commit_req.funct3)
            rv_mem_isa_pkg::f3_byte: store_lanes = 4'b0001;
            rv_mem_isa_pkg::f3_half: store_lanes = 4'b0011;
            rv_mem_isa_pkg::f3_word: store_lanes = 4'b1111;
            default:                 store_lanes = 4'b0000; // No write
        endcase
    end

    assign wr_en    = store_commit && (|store_lanes);
    assign wr_addr  = commit_req.addr;
    assign wr_lanes = store_lanes;
    assign wr_data  = commit_req.value;

    // Load commits reread the same word through the commit port
    assign rd_addr = commit_req.addr;

    assign load_mismatch = checked_load != commit_req.value;

    // Every commit answers one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            commit_resp <= '0;
        end else begin
            commit_resp.done      <= commit_req.valid;
            commit_resp.exception <= load_commit && load_mismatch; // Stores never flag
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_top #(
    parameter int MEM_WORDS = 2048 // At most 2048, the mem_addr_t range
) (
    input  wire                                clk,
    input  wire                                reset,

    input  wire lsu_if_pkg::spec_load_req_t    spec_load_req,
    output logic                               load_valid,
    output rv_mem_isa_pkg::word_t              load_data,

    input  wire lsu_if_pkg::commit_req_t       commit_req,
    output lsu_if_pkg::commit_resp_t           commit_resp
);

    rv_mem_isa_pkg::mem_funct3_e               load_funct3_q; // Follows the raw word
    rv_mem_isa_pkg::word_t                     spec_rd_word;
    rv_mem_isa_pkg::word_t                     cmt_rd_word;
    rv_mem_isa_pkg::word_t                     checked_load;
    lsu_if_pkg::mem_addr_t                     cmt_rd_addr;
    logic                                      wr_en;
    lsu_if_pkg::mem_addr_t                     wr_addr;
    logic [rv_mem_isa_pkg::BYTES_PER_WORD-1:0] wr_lanes;
    rv_mem_isa_pkg::word_t                     wr_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= spec_load_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (spec_load_req.valid) begin
            load_funct3_q <= spec_load_req.funct3;
        end
    end

    data_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_memory (
        .clk          (clk),
        .reset        (reset),
        .spec_rd_en   (spec_load_req.valid),
        .spec_rd_addr (spec_load_req.addr),
        .spec_rd_word (spec_rd_word),
        .cmt_rd_addr  (cmt_rd_addr),
        .cmt_rd_word  (cmt_rd_word),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_lanes     (wr_lanes),
        .wr_data      (wr_data)
    );

    // Speculative result path
    load_extend u_spec_extend (
        .raw    (spec_rd_word),
        .funct3 (load_funct3_q),
        .data   (load_data)
    );

    // Commit reload path
    load_extend u_commit_extend (
        .raw    (cmt_rd_word),
        .funct3 (commit_req.funct3),
        .data   (checked_load)
    );

    commit_unit u_commit_unit (
        .clk          (clk),
        .reset        (reset),
        .commit_req   (commit_req),
        .checked_load (checked_load),
        .rd_addr      (cmt_rd_addr),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_lanes     (wr_lanes),
        .wr_data      (wr_data),
        .commit_resp  (commit_resp)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0; // Released just after an edge
    end

endmodule

`default_nettype wire

// ==== bench/tb_lsu_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_mem;

    localparam int       mem_words        = 2048;
    localparam int       drive_delay      = 1;
    localparam logic [3:0] kind_spec_load   = 4'h1;
    localparam logic [3:0] kind_store       = 4'h2;
    localparam logic [3:0] kind_load_commit = 4'h3;
    localparam logic [3:0] kind_pair        = 4'h4; // Load and store on one edge

    // One record of the stim file
    typedef struct packed {
        logic [7:0]                  kind; // Bit 4 set means no idle gap before
        lsu_if_pkg::mem_addr_t       addr;
        rv_mem_isa_pkg::mem_funct3_e funct3;
        rv_mem_isa_pkg::word_t       data;
        rv_mem_isa_pkg::word_t       expected;
        logic                        exception;
    } stim_rec_t;

    // Responses owed by the DUT one cycle after a drive
    typedef struct packed {
        logic                  load;
        rv_mem_isa_pkg::word_t load_data;
        logic                  commit;
        logic                  exception;
    } expect_t;

    logic                       clk;
    logic                       reset;
    lsu_if_pkg::spec_load_req_t spec_load_req;
    logic                       load_valid;
    rv_mem_isa_pkg::word_t      load_data;
    lsu_if_pkg::commit_req_t    commit_req;
    lsu_if_pkg::commit_resp_t   commit_resp;

    stim_rec_t recs[$];
    string     rec_names[$];
    expect_t   pending;
    string     pending_name;
    int        seed        = 91043;
    int        cycle_count = 0;
    int        cycle_limit = 0; // Set once the records are counted

    tb_clock u_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    lsu_mem_top #(
        .MEM_WORDS (mem_words)
    ) u_lsu_mem_top (
        .clk           (clk),
        .reset         (reset),
        .spec_load_req (spec_load_req),
        .load_valid    (load_valid),
        .load_data     (load_data),
        .commit_req    (commit_req),
        .commit_resp   (commit_resp)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    function automatic string trim_line(input string s);
        int n;
        n = s.len();
        while (n > 0 && (s[n-1] == "\n" || s[n-1] == "\r" || s[n-1] == " ")) begin
            n--;
        end
        return s.substr(0, n - 1);
    endfunction

    task automatic read_stim();
        int          fd;
        int          fields;
        int          line_no;
        string       line;
        string       test_name;
        logic [31:0] f_kind;
        logic [31:0] f_addr;
        logic [31:0] f_funct3;
        logic [31:0] f_data;
        logic [31:0] f_expected;
        logic [31:0] f_exc;
        stim_rec_t   rec;
        fd = $fopen("bench/lsu_mem_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/lsu_mem_stim.txt");
            $display("** FAIL **");
            $fatal(1, "Stimulus file missing");
        end
        test_name = "unnamed";
        line_no   = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            line = trim_line(line);
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            if (line[0] == "@") begin
                test_name = line.substr(2, line.len() - 1); // Group name
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h", f_kind, f_addr, f_funct3,
                             f_data, f_expected, f_exc);
            if (fields != 6) begin
                $display("Stimulus line %0d does not hold six fields", line_no);
                $display("** FAIL **");
                $fatal(1, "Malformed stimulus");
            end
            rec.kind      = f_kind[7:0];
            rec.addr      = lsu_if_pkg::mem_addr_t'(f_addr);
            rec.funct3    = rv_mem_isa_pkg::mem_funct3_e'(f_funct3[2:0]);
            rec.data      = f_data;
            rec.expected  = f_expected;
            rec.exception = f_exc[0];
            recs.push_back(rec);
            rec_names.push_back($sformatf("%s line %0d", test_name, line_no));
        end
        $fclose(fd);
    endtask

    task automatic drive_idle();
        spec_load_req = '0;
        commit_req    = '0;
        pending       = '0; // Nothing may come back
        pending_name  = "idle cycle";
    endtask

    task automatic drive_record(input stim_rec_t rec, input string name);
        expect_t exp_next;
        exp_next      = '0;
        spec_load_req = '0;
        commit_req    = '0;
        case (rec.kind[3:0])
            kind_spec_load, kind_pair: begin
                spec_load_req.valid  = 1'b1;
                spec_load_req.addr   = rec.addr;
                spec_load_req.funct3 = (rec.kind[3:0] == kind_pair) ?
                                       rv_mem_isa_pkg::f3_word : rec.funct3;
                exp_next.load      = 1'b1;
                exp_next.load_data = rec.expected;
            end
            kind_store, kind_load_commit: begin
            end
            default: begin
                $display("Record %s has an unknown kind %h", name, rec.kind);
                $display("** FAIL **");
                $fatal(1, "Bad record kind");
            end
        endcase
        if (rec.kind[3:0] != kind_spec_load) begin
            commit_req.valid    = 1'b1;
            commit_req.is_store = (rec.kind[3:0] != kind_load_commit);
            commit_req.addr     = rec.addr;
            commit_req.funct3   = rec.funct3;
            commit_req.value    = rec.data;
            exp_next.commit     = 1'b1;
            exp_next.exception  = rec.exception;
        end
        pending      = exp_next;
        pending_name = name;
    endtask

    task automatic check_responses();
        check_value($sformatf("%s load_valid", pending_name), 32'(pending.load),
                    32'(load_valid));
        if (pending.load) begin
            check_value($sformatf("%s load_data", pending_name), pending.load_data, load_data);
        end
        check_value($sformatf("%s done", pending_name), 32'(pending.commit),
                    32'(commit_resp.done));
        check_value($sformatf("%s exception", pending_name), 32'(pending.exception),
                    32'(commit_resp.exception));
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycle_count);
            $display("** FAIL **");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        int gap;
        int idx;
        drive_idle();
        read_stim();
        cycle_limit = recs.size() * 4 + 100;
        @(negedge reset);
        for (idx = 0; idx < recs.size(); idx++) begin
            if (!recs[idx].kind[4]) begin
                gap = int'($unsigned($random(seed)) % 3); // 0 to 2 idle cycles
                repeat (gap) begin
                    @(posedge clk);
                    #(drive_delay);
                    check_responses();
                    drive_idle();
                end
            end
            @(posedge clk);
            #(drive_delay);
            check_responses(); // Previous cycle's request
            drive_record(recs[idx], rec_names[idx]);
        end
        repeat (2) begin
            @(posedge clk);
            #(drive_delay);
            check_responses();
            drive_idle();
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/rv_mem_isa_pkg.sv
hdl/lsu_if_pkg.sv
hdl/data_memory.sv
hdl/load_extend.sv
hdl/commit_unit.sv
hdl/lsu_mem_top.sv
bench/tb_clock.sv
bench/tb_lsu_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_lsu_mem \
    -f sources.f \
    -o sim_lsu_mem

status=0
output="$(./obj_dir/sim_lsu_mem 2>&1)" || status=$?
echo "$output"

if [ "$status" -eq 0 ] && echo "$output" | grep -qF '** PASS **'; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== bench/lsu_mem_stim.txt ====
# kind addr funct3 data expected exception, all hex; a line with @ names the records below it
# kind 01 load, 02 store commit, 03 load commit, 04 word load and store on one edge; +10 no gap
@ reset_image
01 000 2 00000000 00000003 0
01 001 2 00000000 00000004 0
01 07f 2 00000000 00000082 0
01 7ff 2 00000000 00000802 0
@ load_extend
02 010 2 12348086 00000000 0
01 010 0 00000000 ffffff86 0
01 010 1 00000000 ffff8086 0
01 010 2 00000000 12348086 0
01 010 4 00000000 00000086 0
01 010 5 00000000 00008086 0
01 010 3 00000000 00000000 0
01 010 7 00000000 00000000 0
@ store_lanes
02 020 2 a1b2c3d4 00000000 0
02 020 0 000000ee 00000000 0
01 020 2 00000000 a1b2c3ee 0
02 020 1 ffff5566 00000000 0
01 020 2 00000000 a1b25566 0
02 020 2 0badf00d 00000000 0
02 020 3 ffffffff 00000000 0
02 020 7 ffffffff 00000000 0
01 020 2 00000000 0badf00d 0
02 021 0 12345678 00000000 0
01 021 2 00000000 00000078 0
01 01f 2 00000000 00000022 0
01 022 2 00000000 00000025 0
@ commit_check
03 010 2 12348086 00000000 0
03 010 0 ffffff86 00000000 0
03 010 4 00000086 00000000 0
03 010 1 ffff8086 00000000 0
03 010 5 00008086 00000000 0
03 010 2 12348087 00000000 1
03 010 0 00000086 00000000 1
03 005 2 00000008 00000000 0
03 005 2 00000009 00000000 1
03 005 3 00000000 00000000 0
@ same_edge
04 030 2 cafef00d 00000033 0
11 030 2 00000000 cafef00d 0
04 031 0 000000aa 00000034 0
11 031 2 00000000 000000aa 0
@ back_to_back
01 040 2 00000000 00000043 0
12 040 2 55aa55aa 00000000 0
11 040 2 00000000 55aa55aa 0
13 040 2 55aa55aa 00000000 0
13 040 4 000000aa 00000000 0
11 041 2 00000000 00000044 0
13 041 2 00000045 00000000 1
12 041 1 0000beef 00000000 0
11 041 1 00000000 ffffbeef 0
14 042 2 77777777 00000045 0
11 042 2 00000000 77777777 0
11 7ff 5 00000000 00000802 0
